// ==== bank_sched.f ====
+incdir+source
source/bank_sched_pkg.sv
source/bank_fifo_if.sv
source/req_fifo.sv
source/fifo_select.sv
source/fifo_drain.sv
source/bank_sched.sv
sim/bank_sched_properties.sv
sim/bank_sched_tb.sv

// ==== sim/bank_sched_input.txt ====
# valid type row col idx data issue_en exp_drop, one cycle per line, all hex
# type 1 is read, 0 is write; read data is ignored by the scheduler
1 1 0100 010 01 0000 0 0
1 1 0100 011 02 0000 0 0
1 1 0200 020 03 0000 0 0
1 1 0300 030 04 0000 0 0
1 1 0400 040 05 0000 0 0
1 1 0500 050 06 0000 0 0
1 1 0500 051 07 0000 0 0
1 0 0100 060 08 abcd 0 0
1 0 0600 070 09 1234 0 0
1 0 0600 071 0a 5678 0 0
1 0 0700 080 0b 9abc 0 0
1 0 0800 090 0c def0 0 0
1 0 0900 0a0 0d 0f0f 0 0
1 0 0a00 0b0 0e ffff 0 1
1 1 0300 0c0 0f 0000 1 0
1 0 0b00 0d0 10 1111 1 1
0 0 0000 000 00 0000 1 0
0 0 0000 000 00 0000 1 0
0 0 0000 000 00 0000 1 0
0 0 0000 000 00 0000 1 0
0 0 0000 000 00 0000 1 0
0 0 0000 000 00 0000 1 0
0 0 0000 000 00 0000 1 0
0 0 0000 000 00 0000 1 0

// ==== sim/bank_sched_properties.sv ====
`timescale 1ns/1ps

module bank_sched_properties (
   input logic clk,
   input logic reset_i,
   input logic issue_en_i,
   input logic drop_o,
   input logic issue_valid_o
);

   // both status outputs are driven once out of reset
   a_known: assert property (@(posedge clk) disable iff (reset_i)
      !$isunknown({drop_o, issue_valid_o}))
      else $error("drop_o or issue_valid_o is unknown");

   // an issue needs the enable one cycle earlier
   a_issue_en: assert property (@(posedge clk) disable iff (reset_i)
      issue_valid_o |-> $past(issue_en_i))
      else $error("issue_valid_o high without issue_en_i in the cycle before");

   // first cycle out of reset is quiet
   a_reset_quiet: assert property (@(posedge clk)
      $past(reset_i) && !reset_i |-> !issue_valid_o)
      else $error("issue_valid_o high in the first cycle after reset");

endmodule

bind bank_sched bank_sched_properties u_props (
   .clk           (clk),
   .reset_i       (reset_i),
   .issue_en_i    (issue_en_i),
   .drop_o        (drop_o),
   .issue_valid_o (issue_valid_o)
);

// ==== sim/bank_sched_tb.sv ====
`timescale 1ns/1ps
`include "bank_sched_macros.svh"

module bank_sched_tb import bank_sched_pkg::*; ();

   localparam int CLK_PERIOD = 20;
   localparam int RESET_CYC  = 8;
   localparam int MID_RST    = 3;   // reset in the middle of the run
   localparam int IDLE_N     = 3;
   localparam int FILL_N     = `RD_FIFO_NUM * `RD_FIFO_DEPTH + 1;  // one read past capacity
   localparam int RAND_N     = 300;
   localparam int DRAIN_N    = 26;  // more than all fifos hold together

   // one stimulus line
   typedef struct packed {
      logic      valid;
      logic      rtype;
      row_addr_t row;
      col_addr_t col;
      req_idx_t  idx;
      wr_data_t  data;
      logic      en;
      logic      drop;  // expected drop_o, file lines only
   } vec_t;

   logic      clk;
   logic      reset_i;
   logic      req_valid_i;
   logic      req_type_i;
   row_addr_t req_row_i;
   col_addr_t req_col_i;
   req_idx_t  req_idx_i;
   wr_data_t  req_data_i;
   logic      drop_o;
   logic      issue_en_i;
   logic      issue_valid_o;
   logic      issue_type_o;
   row_addr_t issue_row_o;
   col_addr_t issue_col_o;
   req_idx_t  issue_idx_o;
   wr_data_t  issue_data_o;

   vec_t        vec_q [$];
   bit          loaded = 1'b0;
   logic [31:0] lcg_state = 32'd64;
   row_addr_t   hot_rows [4] = '{16'h0100, 16'h0200, 16'h0300, 16'h0400};  // so hits occur

   // reference model with one queue per fifo
   sched_entry_t mq [`FIFO_NUM][$];
   row_addr_t    m_last [`FIFO_NUM];  // row of the newest push
   logic         exp_valid;
   logic         exp_type;
   sched_entry_t exp_entry;

   bank_sched dut_i (
      .clk           (clk),
      .reset_i       (reset_i),
      .req_valid_i   (req_valid_i),
      .req_type_i    (req_type_i),
      .req_row_i     (req_row_i),
      .req_col_i     (req_col_i),
      .req_idx_i     (req_idx_i),
      .req_data_i    (req_data_i),
      .drop_o        (drop_o),
      .issue_en_i    (issue_en_i),
      .issue_valid_o (issue_valid_o),
      .issue_type_o  (issue_type_o),
      .issue_row_o   (issue_row_o),
      .issue_col_o   (issue_col_o),
      .issue_idx_o   (issue_idx_o),
      .issue_data_o  (issue_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic int depth_of(input int f);
      return (f < `RD_FIFO_NUM) ? `RD_FIFO_DEPTH : `WR_FIFO_DEPTH;
   endfunction

   // target fifo by the four-step rule or -1 for a drop
   function automatic int pick_fifo(input logic rtype, input row_addr_t row);
      int   lo;
      int   hi;
      int   n;
      int   dep;
      logic ok;
      lo = (rtype == `REQ_READ) ? 0 : `RD_FIFO_NUM;
      hi = (rtype == `REQ_READ) ? `RD_FIFO_NUM : `FIFO_NUM;
      for (int cls = 0; cls < 4; cls++) begin
         for (int i = lo; i < hi; i++) begin
            n   = mq[i].size();
            dep = depth_of(i);
            case (cls)
               0:       ok = (n > 0) && (m_last[i] == row);  // row hit
               1:       ok = (n == 0);
               2:       ok = (2 * n < dep);                  // below half
               default: ok = 1'b1;
            endcase
            if (n < dep && ok) return i;  // full never takes one
         end
      end
      return -1;
   endfunction

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      assert (got === exp) else begin
         $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1, "stopped at the first error");
      end
   endtask

   // issue outputs against the pop the model made at the last edge
   task automatic compare_issue();
      row_addr_t er;
      req_idx_t  ei;
      col_addr_t ec;
      wr_data_t  ed;
      check_val("issue_valid_o", issue_valid_o, exp_valid);  // set at the last rising edge
      if (exp_valid) begin
         {er, ei, ec, ed} = exp_entry;
         check_val("issue_type_o", issue_type_o, exp_type);
         check_val("issue_row_o", issue_row_o, er);
         check_val("issue_col_o", issue_col_o, ec);
         check_val("issue_idx_o", issue_idx_o, ei);
         check_val("issue_data_o", issue_data_o, ed);
      end
   endtask

   task automatic read_vectors();
      int          fd;
      int          n;
      string       line;
      logic [31:0] c [8];
      vec_t        v;
      fd = $fopen("sim/bank_sched_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file sim/bank_sched_input.txt");
         $display("Simulation failed");
         $fatal(1, "no stimulus");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 8 || line[0] == "#") continue;  // blank or column notes
         n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                     c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7]);
         if (n != 8) begin
            $display("Stimulus line has %0d fields instead of 8: %s", n, line);
            $display("Simulation failed");
            $fatal(1, "bad stimulus");
         end
         v.valid = c[0][0];
         v.rtype = c[1][0];
         v.row   = row_addr_t'(c[2]);
         v.col   = col_addr_t'(c[3]);
         v.idx   = req_idx_t'(c[4]);
         v.data  = wr_data_t'(c[5]);
         v.en    = c[6][0];
         v.drop  = c[7][0];
         vec_q.push_back(v);
      end
      $fclose(fd);
      loaded = 1'b1;
   endtask

   // one clock of checks, drive and model update
   task automatic run_cycle(input vec_t v, input bit from_file);
      int tgt;
      int src;
      @(negedge clk);
      compare_issue();
      req_valid_i = v.valid;
      req_type_i  = v.rtype;
      req_row_i   = v.row;
      req_col_i   = v.col;
      req_idx_i   = v.idx;
      req_data_i  = v.data;
      issue_en_i  = v.en;
      #2;
      tgt = v.valid ? pick_fifo(v.rtype, v.row) : -1;
      check_val("drop_o", drop_o, v.valid && tgt < 0);
      if (from_file) check_val("drop_o", drop_o, v.drop);
      // pop and push both decided on the state before the edge
      src = -1;
      if (v.en) begin
         for (int i = 0; i < `FIFO_NUM; i++) begin
            if (src < 0 && mq[i].size() > 0) src = i;  // reads sit lowest
         end
      end
      exp_valid = (src >= 0);
      if (src >= 0) begin
         exp_type  = (src < `RD_FIFO_NUM) ? `REQ_READ : `REQ_WRITE;
         exp_entry = mq[src].pop_front();
      end
      if (tgt >= 0) begin
         mq[tgt].push_back({v.row, v.idx, v.col,
                            (v.rtype == `REQ_READ) ? wr_data_t'(0) : v.data});
         m_last[tgt] = v.row;
      end
   endtask

   task automatic apply_reset(input int cycles);
      @(negedge clk);
      compare_issue();
      reset_i     = 1'b1;
      req_valid_i = 1'b0;
      issue_en_i  = 1'b0;
      repeat (cycles) @(negedge clk);
      reset_i = 1'b0;
      foreach (mq[i]) mq[i].delete();
      exp_valid = 1'b0;
   endtask

   initial begin
      vec_t        v;
      logic [31:0] r1;
      logic [31:0] r2;
      reset_i     = 1'b1;
      req_valid_i = 1'b0;
      req_type_i  = 1'b0;
      req_row_i   = '0;
      req_col_i   = '0;
      req_idx_i   = '0;
      req_data_i  = '0;
      issue_en_i  = 1'b0;
      exp_valid   = 1'b0;
      exp_type    = 1'b0;
      exp_entry   = '0;
      read_vectors();
      repeat (RESET_CYC) @(negedge clk);
      reset_i = 1'b0;
      foreach (vec_q[i]) run_cycle(vec_q[i], 1'b1);
      apply_reset(MID_RST);  // fifos still hold entries here
      v    = '0;
      v.en = 1'b1;
      repeat (IDLE_N) run_cycle(v, 1'b0);  // nothing to issue after reset
      // with issue held the last read finds every read fifo full
      v       = '0;
      v.valid = 1'b1;
      v.rtype = `REQ_READ;
      for (int k = 0; k < FILL_N; k++) begin
         v.row = hot_rows[k % 4];
         v.idx = req_idx_t'(k);
         run_cycle(v, 1'b0);
      end
      for (int k = 0; k < RAND_N; k++) begin
         r1      = next_random();
         r2      = next_random();
         v.valid = (r1[31:30] != 2'b00);
         v.rtype = r1[29];
         v.row   = hot_rows[r1[28:27]];
         v.col   = r1[26:17];
         v.idx   = r1[16:10];
         v.data  = r2[29:14];
         // first half backs up and drops while the second half drains
         v.en    = (k < RAND_N / 2) ? (r2[31:30] == 2'b00) : (r2[31:30] != 2'b00);
         run_cycle(v, 1'b0);
      end
      v    = '0;
      v.en = 1'b1;
      repeat (DRAIN_N) run_cycle(v, 1'b0);
      @(negedge clk);
      compare_issue();  // issue from the last drain cycle
      $display("Simulation passed");
      $finish;
   end

   // watchdog sized from the stimulus length
   initial begin
      wait (loaded);
      #((vec_q.size() + RAND_N + 20 + RESET_CYC + MID_RST + IDLE_N + FILL_N + DRAIN_N)
        * CLK_PERIOD);
      $display("Timeout, the test did not finish in the expected number of cycles");
      $display("Simulation failed");
      $fatal(1, "watchdog");
   end

endmodule

// ==== source/bank_fifo_if.sv ====
`timescale 1ns/1ps

// status and control of one scheduler fifo
interface bank_fifo_if import bank_sched_pkg::*; ();

   logic         push;        // from selector, one cycle per request
   sched_entry_t push_entry;  // packed request
   logic         pop;         // from drain
   sched_entry_t head_entry;  // oldest entry, valid when not empty
   logic         full;
   logic         mid;         // at least half full
   logic         empty;
   row_addr_t    last_ra;     // row of the newest push

   // selector side
   modport sel (
      output push, push_entry,
      input  full, mid, empty, last_ra
   );

   // drain side only needs the head and empty
   modport drain (
      output pop,
      input  head_entry, empty
   );

   modport fifo (
      input  push, push_entry, pop,
      output head_entry, full, mid, empty, last_ra
   );

endinterface

// ==== source/bank_sched.sv ====
`timescale 1ns/1ps
`include "bank_sched_macros.svh"

module bank_sched import bank_sched_pkg::*; (
   input  logic       clk,
   input  logic       reset_i,
   // request in, already routed to this bank
   input  logic       req_valid_i,
   input  logic       req_type_i,    // 1 read, 0 write
   input  row_addr_t  req_row_i,
   input  col_addr_t  req_col_i,
   input  req_idx_t   req_idx_i,
   input  wr_data_t   req_data_i,
   output logic       drop_o,        // same cycle as the request
   // issue side
   input  logic       issue_en_i,
   output logic       issue_valid_o,
   output logic       issue_type_o,
   output row_addr_t  issue_row_o,
   output col_addr_t  issue_col_o,
   output req_idx_t   issue_idx_o,
   output wr_data_t   issue_data_o
);

   // 0..3 read fifos, 4..6 write fifos
   bank_fifo_if fq [`FIFO_NUM] ();

   for (genvar i = 0; i < `FIFO_NUM; i++) begin : g_fifo
      if (i < `RD_FIFO_NUM) begin : g_rd
         req_fifo #(
            .DEPTH   (`RD_FIFO_DEPTH)
         ) u_fifo (
            .clk     (clk),
            .reset_i (reset_i),
            .f       (fq[i])
         );
      end else begin : g_wr
         req_fifo #(
            .DEPTH   (`WR_FIFO_DEPTH)  // writes are shallower
         ) u_fifo (
            .clk     (clk),
            .reset_i (reset_i),
            .f       (fq[i])
         );
      end
   end

   // picks a fifo per request
   fifo_select u_select (
      .req_valid_i (req_valid_i),
      .req_type_i  (req_type_i),
      .req_row_i   (req_row_i),
      .req_col_i   (req_col_i),
      .req_idx_i   (req_idx_i),
      .req_data_i  (req_data_i),
      .drop_o      (drop_o),
      .q           (fq)
   );

   // pops one head per enabled cycle
   fifo_drain u_drain (
      .clk           (clk),
      .reset_i       (reset_i),
      .issue_en_i    (issue_en_i),
      .q             (fq),
      .issue_valid_o (issue_valid_o),
      .issue_type_o  (issue_type_o),
      .issue_row_o   (issue_row_o),
      .issue_col_o   (issue_col_o),
      .issue_idx_o   (issue_idx_o),
      .issue_data_o  (issue_data_o)
   );

endmodule

// ==== source/bank_sched_macros.svh ====
`ifndef BANK_SCHED_MACROS_SVH
`define BANK_SCHED_MACROS_SVH

// request field widths
`define RA_W           16
`define CA_W           10
`define IDX_W          7
`define DQ_W           16

// stored entry is row, index, column, data from msb down
`define ENTRY_W        (`RA_W + `IDX_W + `CA_W + `DQ_W)

// scheduler fifo counts
// read fifos sit on the low indices, write fifos above them
`define RD_FIFO_NUM    4
`define WR_FIFO_NUM    3
`define FIFO_NUM       (`RD_FIFO_NUM + `WR_FIFO_NUM)

// entries per fifo
`define RD_FIFO_DEPTH  4
`define WR_FIFO_DEPTH  2

// request type codes
`define REQ_READ       1'b1
`define REQ_WRITE      1'b0

`endif

// ==== source/bank_sched_pkg.sv ====
`include "bank_sched_macros.svh"

package bank_sched_pkg;

   // address and payload fields of one request
   typedef logic [`RA_W-1:0]  row_addr_t;  // dram row
   typedef logic [`CA_W-1:0]  col_addr_t;  // dram column
   typedef logic [`IDX_W-1:0] req_idx_t;   // transaction index, returned on issue
   typedef logic [`DQ_W-1:0]  wr_data_t;   // write data, zero for reads

   // one bit per scheduler fifo, bit 0 is read fifo 0
   typedef logic [`FIFO_NUM-1:0] fifo_mask_t;

   // entry as held in a fifo slot
   // {row, idx, col, data}, 49 bits
   typedef logic [`ENTRY_W-1:0] sched_entry_t;

endpackage

// ==== source/fifo_drain.sv ====
`timescale 1ns/1ps
`include "bank_sched_macros.svh"

module fifo_drain import bank_sched_pkg::*; (
   input  logic        clk,
   input  logic        reset_i,
   input  logic        issue_en_i,   // command side can take one
   bank_fifo_if.drain  q [`FIFO_NUM],
   output logic        issue_valid_o,
   output logic        issue_type_o,
   output row_addr_t   issue_row_o,
   output col_addr_t   issue_col_o,
   output req_idx_t    issue_idx_o,
   output wr_data_t    issue_data_o
);

   localparam int SEL_W = $clog2(`FIFO_NUM);

   fifo_mask_t       empty_v;
   sched_entry_t     head_a [`FIFO_NUM];
   logic [SEL_W-1:0] sel_idx;   // lowest non-empty fifo
   logic             any_ne;
   logic             do_pop;

   for (genvar g = 0; g < `FIFO_NUM; g++) begin : g_q
      assign empty_v[g] = q[g].empty;
      assign head_a[g]  = q[g].head_entry;
      assign q[g].pop   = do_pop && (sel_idx == SEL_W'(g));
   end

   // read fifos hold the low indices, so lowest index first
   // serves every read before any write
   always_comb begin
      sel_idx = '0;
      for (int i = `FIFO_NUM - 1; i >= 0; i--) begin
         if (!empty_v[i]) sel_idx = SEL_W'(i);
      end
   end

   assign any_ne = ~&empty_v;
   assign do_pop = issue_en_i && any_ne;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         issue_valid_o <= 1'b0;
      end else begin
         issue_valid_o <= do_pop;  // one cycle after the pop
      end
   end

   // issue fields, held between issues
   always_ff @(posedge clk) begin
      if (do_pop) begin
         issue_type_o <= (sel_idx < SEL_W'(`RD_FIFO_NUM)) ? `REQ_READ : `REQ_WRITE;
         {issue_row_o, issue_idx_o, issue_col_o, issue_data_o} <= head_a[sel_idx];
      end
   end

endmodule

// ==== source/fifo_select.sv ====
`timescale 1ns/1ps
`include "bank_sched_macros.svh"

module fifo_select import bank_sched_pkg::*; (
   input  logic       req_valid_i,
   input  logic       req_type_i,
   input  row_addr_t  req_row_i,
   input  col_addr_t  req_col_i,
   input  req_idx_t   req_idx_i,
   input  wr_data_t   req_data_i,
   output logic       drop_o,
   bank_fifo_if.sel   q [`FIFO_NUM]
);

   // reads on the low bits, writes on the rest
   localparam fifo_mask_t RD_MASK = fifo_mask_t'((1 << `RD_FIFO_NUM) - 1);
   localparam fifo_mask_t WR_MASK = ~RD_MASK;

   fifo_mask_t   full_v;
   fifo_mask_t   mid_v;
   fifo_mask_t   empty_v;
   fifo_mask_t   row_eq_v;   // last_ra matches the request row
   fifo_mask_t   kind_v;     // fifos of the request's type
   fifo_mask_t   cand_v;     // may take the request at all
   fifo_mask_t   hit_v;
   fifo_mask_t   emp_v;
   fifo_mask_t   low_v;
   fifo_mask_t   pick_v;     // winning class, may have several bits
   fifo_mask_t   push_v;     // one hot
   wr_data_t     data_v;
   sched_entry_t entry;

   // flatten the interface array into masks
   for (genvar g = 0; g < `FIFO_NUM; g++) begin : g_q
      assign full_v[g]   = q[g].full;
      assign mid_v[g]    = q[g].mid;
      assign empty_v[g]  = q[g].empty;
      assign row_eq_v[g] = (q[g].last_ra == req_row_i);
      assign q[g].push       = push_v[g];
      assign q[g].push_entry = entry;  // only the pushed fifo takes it
   end

   assign kind_v = (req_type_i == `REQ_READ) ? RD_MASK : WR_MASK;
   assign cand_v = req_valid_i ? (kind_v & ~full_v) : '0;

   // the three preferred classes, all inside the candidates
   assign hit_v = cand_v & ~empty_v & row_eq_v;  // open row, keep it busy
   assign emp_v = cand_v & empty_v;
   assign low_v = cand_v & ~mid_v;               // spread before stacking

   // first class that has anyone in it wins
   always_comb begin
      if (hit_v != '0) begin
         pick_v = hit_v;
      end else if (emp_v != '0) begin
         pick_v = emp_v;
      end else if (low_v != '0) begin
         pick_v = low_v;
      end else begin
         pick_v = cand_v;  // whatever is left, may be none
      end
   end

   assign push_v = pick_v & (~pick_v + 1'b1);  // keep lowest set bit

   // nothing to take it, request is lost
   assign drop_o = req_valid_i && (cand_v == '0);

   assign data_v = (req_type_i == `REQ_READ) ? wr_data_t'(0) : req_data_i;
   assign entry  = {req_row_i, req_idx_i, req_col_i, data_v};

endmodule

// ==== source/req_fifo.sv ====
`timescale 1ns/1ps
`include "bank_sched_macros.svh"

module req_fifo import bank_sched_pkg::*; #(
   parameter int DEPTH = `RD_FIFO_DEPTH
) (
   input  logic       clk,
   input  logic       reset_i,
   bank_fifo_if.fifo  f
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);  // counts 0..DEPTH

   sched_entry_t     mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push_ok;
   logic             pop_ok;

   // status comes straight off the count
   assign f.full  = (count == CNT_W'(DEPTH));
   assign f.empty = (count == '0);
   assign f.mid   = (count >= CNT_W'(DEPTH / 2));

   // full blocks a push even when a pop happens in the same cycle
   assign push_ok = f.push && !f.full;
   assign pop_ok  = f.pop && !f.empty;

   assign f.head_entry = mem[rd_ptr];  // first word fall through

   // pointers and count
   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
         end
         if (pop_ok) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // none, or push and pop together
         endcase
      end
   end

   // storage and last row, no reset
   // last_ra is only looked at while the fifo holds something
   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr] <= f.push_entry;
         f.last_ra   <= f.push_entry[`ENTRY_W-1 -: `RA_W];  // row sits on top
      end
   end

endmodule
